/* bench/axi_mem_model.sv */
/*
 * AXI slave memory for the cache testbench
 * 16 K words preset to address XOR A5A50000, random 0 to 3 cycle
 * delays on every ready and on rvalid and bvalid, handshake counters
 */
`default_nettype none

module axi_mem_model (
    input  wire                         aclk,
    input  wire                         aresetn,
    input  wire  dcache_pkg::axi_addr_t ar,
    input  wire                         arvalid,
    output logic                        arready,
    output dcache_pkg::axi_r_t          r,
    output logic                        rvalid,
    input  wire  dcache_pkg::axi_addr_t aw,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire  dcache_pkg::axi_w_t    w,
    input  wire                         wvalid,
    output logic                        wready,
    output logic                        bvalid,
    output int                          ar_count,
    output int                          aw_count,
    output logic [3:0]                  last_ar_len,
    output logic [3:0]                  last_aw_len,
    output logic [3:0]                  last_wstrb
);
    import dcache_pkg::*;

    localparam int words = 16384;

    logic [31:0] mem [words];
    logic [31:0] lfsr = 32'h5175;
    logic        rd_active;
    logic [13:0] rd_addr;
    logic [3:0]  rd_left;
    logic [1:0]  rd_wait;
    logic [1:0]  ar_wait;
    logic        wr_active;
    logic [13:0] wr_addr;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        b_pending;
    logic [1:0]  b_wait;

    initial begin
        for (int i = 0; i < words; i++) begin
            mem[i] = i ^ 32'hA5A50000;
        end
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // two LFSR steps, one bit taken from each
    task automatic pick_delay(output logic [1:0] d);
        lfsr = galois_step(lfsr);
        d[0] = lfsr[0];
        lfsr = galois_step(lfsr);
        d[1] = lfsr[0];
    endtask

    always @(posedge aclk or negedge aresetn) begin
        logic [1:0] d;
        if (!aresetn) begin
            arready     <= 1'b0;
            rvalid      <= 1'b0;
            r           <= '0;
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            ar_count    <= 0;
            aw_count    <= 0;
            last_ar_len <= '0;
            last_aw_len <= '0;
            last_wstrb  <= '0;
            rd_active   <= 1'b0;
            rd_addr     <= '0;
            rd_left     <= '0;
            rd_wait     <= '0;
            ar_wait     <= '0;
            wr_active   <= 1'b0;
            wr_addr     <= '0;
            aw_wait     <= '0;
            w_wait      <= '0;
            b_pending   <= 1'b0;
            b_wait      <= '0;
        end else begin
            // read address channel
            if (arvalid && arready) begin
                ar_count    <= ar_count + 1;
                last_ar_len <= ar.len;
                arready     <= 1'b0;
                rd_active   <= 1'b1;
                rd_addr     <= ar.addr[15:2];
                rd_left     <= ar.len;
                pick_delay(d);
                rd_wait <= d;
                pick_delay(d);
                ar_wait <= d;
            end else if (arvalid && !rd_active) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end

            // read beats, each taken on the edge after rvalid rises
            if (rd_active) begin
                if (rvalid) begin
                    rvalid  <= 1'b0;
                    rd_addr <= rd_addr + 14'd1;
                    if (r.last) begin
                        rd_active <= 1'b0;
                    end else begin
                        rd_left <= rd_left - 4'd1;
                    end
                    pick_delay(d);
                    rd_wait <= d;
                end else if (rd_wait != 2'd0) begin
                    rd_wait <= rd_wait - 2'd1;
                end else begin
                    rvalid <= 1'b1;
                    r.data <= mem[rd_addr];
                    r.last <= (rd_left == 4'd0);
                end
            end

            // write address channel
            if (awvalid && awready) begin
                aw_count    <= aw_count + 1;
                last_aw_len <= aw.len;
                awready     <= 1'b0;
                wr_active   <= 1'b1;
                wr_addr     <= aw.addr[15:2];
                pick_delay(d);
                aw_wait <= d;
            end else if (awvalid && !wr_active && !b_pending) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end

            // write data channel
            if (wvalid && wready) begin
                wready     <= 1'b0;
                last_wstrb <= w.strb;
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i]) begin
                        mem[wr_addr][8*i +: 8] <= w.data[8*i +: 8];
                    end
                end
                wr_addr <= wr_addr + 14'd1;
                pick_delay(d);
                w_wait <= d;
                if (w.last) begin
                    wr_active <= 1'b0;
                    b_pending <= 1'b1;
                    pick_delay(d);
                    b_wait <= d;
                end
            end else if (wvalid && wr_active) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end

            // one response pulse per burst
            if (b_pending) begin
                if (bvalid) begin
                    bvalid    <= 1'b0;
                    b_pending <= 1'b0;
                end else if (b_wait != 2'd0) begin
                    b_wait <= b_wait - 2'd1;
                end else begin
                    bvalid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/dcache_tb.sv */
/*
 * data cache testbench
 * replays the access vectors against the cache and an AXI memory,
 * checking read data and address handshake counts per access
 */
`default_nettype none

module dcache_tb;
    import dcache_pkg::*;

    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  cached;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] rdata;
        logic [7:0]  ar_n;
        logic [7:0]  aw_n;
    } vec_t;

    logic        aclk;
    logic        aresetn;
    logic        bus_en;
    cpu_req_t    bus_req;
    logic        bus_stall;
    logic [31:0] bus_rdata;
    logic        bus_streq;
    axi_addr_t   ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    axi_addr_t   aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    int          ar_count;
    int          aw_count;
    logic [3:0]  last_ar_len;
    logic [3:0]  last_aw_len;
    logic [3:0]  last_wstrb;

    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    vec_t        vecs[$];
    logic [31:0] lfsr = 32'h5175;

    tb_clock_gen clk_gen_i (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    axi_mem_model mem_i (
        .aclk (aclk), .aresetn (aresetn),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready), .bvalid (bvalid),
        .ar_count (ar_count), .aw_count (aw_count),
        .last_ar_len (last_ar_len), .last_aw_len (last_aw_len),
        .last_wstrb (last_wstrb)
    );

    dcache_top dcache_top_i (
        .aclk (aclk), .aresetn (aresetn),
        .bus_en (bus_en), .bus_req (bus_req), .bus_stall (bus_stall),
        .bus_rdata (bus_rdata), .bus_streq (bus_streq),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .r (r), .rvalid (rvalid),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready), .bvalid (bvalid)
    );

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the cache did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic expect_word(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [8];
        vec_t        v;
        fd = $fopen("bench/dcache_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file bench/dcache_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                // comment and blank lines scan no fields
                if (n == 8) begin
                    v = '{op: f[0][3:0], cached: f[1][3:0], addr: f[2], wdata: f[3],
                          be: f[4][3:0], rdata: f[5], ar_n: f[6][7:0], aw_n: f[7][7:0]};
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
            if (vecs.size() == 0) begin
                $display("the vector file holds no accesses");
                errors++;
            end
        end
    endtask

    task automatic run_access(input vec_t v);
        int   ar0;
        int   aw0;
        logic stall_bit;
        ar0       = ar_count;
        aw0       = aw_count;
        stall_bit = 1'b0;
        if (v.cached[0] == 1'b0) begin
            lfsr      = galois_step(lfsr);
            stall_bit = lfsr[0];
        end
        @(posedge aclk);
        bus_en         <= 1'b1;
        bus_req.addr   <= v.addr;
        bus_req.wdata  <= v.wdata;
        bus_req.wen    <= v.op[0] ? v.be : 4'h0;
        bus_req.size   <= 2'b10;
        bus_req.cached <= v.cached[0];
        bus_stall      <= stall_bit;
        @(negedge aclk);
        // a hit never stalls
        if (v.cached[0] && v.ar_n == 8'd0 && v.aw_n == 8'd0) begin
            expect_word("bus_streq", 32'd0, {31'd0, bus_streq});
        end
        while (bus_streq) begin
            @(negedge aclk);
        end
        if (stall_bit) begin
            // pipeline stalled for one edge, result must stay buffered
            @(posedge aclk);
            bus_stall <= 1'b0;
            @(negedge aclk);
            while (bus_streq) begin
                @(negedge aclk);
            end
        end
        // accepting edge, request stays put for the data cycle
        @(posedge aclk);
        bus_en    <= 1'b0;
        bus_stall <= 1'b0;
        @(negedge aclk);
        if (!v.op[0]) begin
            expect_word("bus_rdata", v.rdata, bus_rdata);
        end
        expect_word("ar_count", ar0 + v.ar_n, ar_count);
        expect_word("aw_count", aw0 + v.aw_n, aw_count);
        if (v.ar_n != 8'd0) begin
            expect_word("ar.len", v.cached[0] ? 32'd15 : 32'd0, {28'd0, last_ar_len});
        end
        if (v.aw_n != 8'd0) begin
            expect_word("aw.len", v.cached[0] ? 32'd15 : 32'd0, {28'd0, last_aw_len});
        end
        if (v.aw_n != 8'd0 && v.cached[0] == 1'b0) begin
            expect_word("w.strb", {28'd0, v.be}, {28'd0, last_wstrb});
        end
    endtask

    initial begin
        bus_en    = 1'b0;
        bus_req   = '0;
        bus_stall = 1'b0;
        load_vectors();
        cycle_limit = vecs.size() * 200;
        @(posedge aclk);
        while (!aresetn) begin
            @(posedge aclk);
        end
        foreach (vecs[i]) begin
            run_access(vecs[i]);
        end
        repeat (2) @(posedge aclk);
        $display("accesses: %0d, errors: %0d", vecs.size(), errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/dcache_vectors.txt */
# op(0 read, 1 write) cached addr wdata byte_en exp_rdata exp_ar exp_aw
# memory word at byte address a starts as (a >> 2) ^ a5a50000; counts are per access
0 1 00000100 00000000 0 a5a50040 1 0
0 1 00000104 00000000 0 a5a50041 0 0
1 1 00000108 11223344 3 00000000 0 0
0 1 00000108 00000000 0 a5a53344 0 0
0 1 00001108 00000000 0 a5a50442 1 1
0 0 00000108 00000000 0 a5a53344 1 0
0 1 00002200 00000000 0 a5a50880 1 0
1 0 00002200 deadbeef c 00000000 0 1
0 0 00002200 00000000 0 dead0880 1 0
0 1 00002200 00000000 0 a5a50880 0 0
1 1 00002204 01234567 f 00000000 0 0
0 1 00002204 00000000 0 01234567 0 0
0 1 00003204 00000000 0 a5a50c81 1 1
0 0 00002204 00000000 0 01234567 1 0
0 0 00002200 00000000 0 a5a50880 1 0
0 1 00000100 00000000 0 a5a50040 1 0
0 1 00000108 00000000 0 a5a53344 0 0
1 0 00003000 000000ab 1 00000000 0 1
0 0 00003000 00000000 0 a5a50cab 1 0
0 1 0000113c 00000000 0 a5a5044f 1 0
1 1 00001138 ffffffff 8 00000000 0 0
0 1 00001138 00000000 0 ffa5044e 0 0

/* bench/tb_clock_gen.sv */
/*
 * testbench clock and reset source
 * period of 40, reset held low for the first two rising edges
 */
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk    = 1'b0;
        aresetn = 1'b0;
        forever #20 aclk = ~aclk;
    end

    initial begin
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;
    end

endmodule

`default_nettype wire

/* design/dcache_data_ram.sv */
/*
 * data cache line store
 * two ports with byte write enables and registered reads;
 * port a serves the processor, port b the fill and writeback engine
 */
`default_nettype none

module dcache_data_ram (
    input  wire                                   aclk,
    input  wire  [dcache_pkg::ram_addr_bits-1:0] port_a_addr,
    input  wire  [3:0]                            port_a_wen,
    input  wire  [31:0]                           port_a_wdata,
    output logic [31:0]                           port_a_rdata,
    input  wire  [dcache_pkg::ram_addr_bits-1:0] port_b_addr,
    input  wire  [3:0]                            port_b_wen,
    input  wire  [31:0]                           port_b_wdata,
    output logic [31:0]                           port_b_rdata
);
    import dcache_pkg::*;

    localparam int depth = (1 << index_bits) * line_words;

    logic [31:0] mem [depth];

    always_ff @(posedge aclk) begin
        for (int i = 0; i < 4; i++) begin
            if (port_a_wen[i]) begin
                mem[port_a_addr][8*i +: 8] <= port_a_wdata[8*i +: 8];
            end
            if (port_b_wen[i]) begin
                mem[port_b_addr][8*i +: 8] <= port_b_wdata[8*i +: 8];
            end
        end
        // read before write on both ports
        port_a_rdata <= mem[port_a_addr];
        port_b_rdata <= mem[port_b_addr];
    end

endmodule

`default_nettype wire

/* design/dcache_miss_fsm.sv */
/*
 * data cache miss engine
 * runs line fills, dirty writebacks and uncached single transfers
 * on the AXI channels, one at a time, and holds the uncached result
 */
`default_nettype none

module dcache_miss_fsm (
    input  wire                                   aclk,
    input  wire                                   aresetn,
    input  wire                                   bus_en,
    input  wire  dcache_pkg::cpu_req_t            bus_req,
    input  wire                                   bus_stall,
    input  wire                                   stall_out,
    input  wire                                   hit,
    input  wire                                   victim_dirty,
    input  wire  dcache_pkg::line_state_t         victim,
    output logic                                  claim_line,
    output logic                                  fill_done,
    output logic                                  wb_done,
    output logic [dcache_pkg::index_bits-1:0]     fill_index,
    output logic                                  ram_busy,
    output logic [dcache_pkg::ram_addr_bits-1:0]  ram_b_addr,
    output logic [3:0]                            ram_b_wen,
    output logic [31:0]                           ram_b_wdata,
    input  wire  [31:0]                           ram_b_rdata,
    output logic [31:0]                           uc_rdata,
    output logic                                  uc_ready,
    output dcache_pkg::axi_addr_t                 ar,
    output logic                                  arvalid,
    input  wire                                   arready,
    input  wire  dcache_pkg::axi_r_t              r,
    input  wire                                   rvalid,
    output dcache_pkg::axi_addr_t                 aw,
    output logic                                  awvalid,
    input  wire                                   awready,
    output dcache_pkg::axi_w_t                    w,
    output logic                                  wvalid,
    input  wire                                   wready,
    input  wire                                   bvalid
);
    import dcache_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_fill_prep, st_fill_xfer, st_fill_end,
        st_wb_prep, st_wb_xfer, st_wb_end,
        st_ucr_prep, st_ucr_xfer, st_ucr_wait,
        st_ucw_prep, st_ucw_xfer, st_ucw_resp, st_ucw_wait
    } state_t;

    state_t                         state;
    logic [$clog2(line_words)-1:0] cnt;
    logic [31:0]                    lk_addr;
    logic [31:0]                    lk_data;
    logic [3:0]                     lk_strb;
    logic [1:0]                     lk_size;
    logic                           lk_cached;
    logic                           uc_valid;
    logic                           uc_wrdy;
    logic                           req_write;
    logic                           start_wb;
    logic                           start_fill;
    logic                           start_ucr;
    logic                           start_ucw;
    axi_addr_t                      xfer_addr;

    assign req_write  = |bus_req.wen;
    assign start_wb   = (state == st_idle) && bus_en && bus_req.cached && !hit && victim_dirty;
    assign start_fill = (state == st_idle) && bus_en && bus_req.cached && !hit && !victim_dirty;
    assign start_ucr  = (state == st_idle) && bus_en && !bus_req.cached && !req_write;
    assign start_ucw  = (state == st_idle) && bus_en && !bus_req.cached && req_write;

    assign claim_line = start_fill;
    assign fill_done  = (state == st_fill_end);
    assign wb_done    = (state == st_wb_end) && bvalid;
    assign fill_index = lk_addr[offset_bits +: index_bits];

    // fill writes straight from the read channel
    assign ram_b_addr  = {fill_index, cnt};
    assign ram_b_wen   = (state == st_fill_xfer && rvalid) ? 4'hf : 4'h0;
    assign ram_b_wdata = r.data;

    // address payload only changes in idle, so it is stable under valid
    assign xfer_addr.addr = lk_addr;
    assign xfer_addr.len  = lk_cached ? burst_len_line : burst_len_single;
    assign xfer_addr.size = lk_cached ? size_word : {1'b0, lk_size};
    assign ar = xfer_addr;
    assign aw = xfer_addr;

    assign w.data = lk_cached ? ram_b_rdata : lk_data;
    assign w.strb = lk_cached ? 4'hf : lk_strb;
    assign w.last = lk_cached ? (&cnt) : 1'b1;

    assign uc_ready = (uc_valid && lk_addr == bus_req.addr) || uc_wrdy;

    always_ff @(posedge aclk) begin
        if (start_wb) begin
            lk_addr <= {victim.tag, bus_req.addr[offset_bits +: index_bits],
                        {offset_bits{1'b0}}};
        end else if (start_fill) begin
            lk_addr <= {bus_req.addr[31:offset_bits], {offset_bits{1'b0}}};
        end else if (start_ucr || start_ucw) begin
            lk_addr <= bus_req.addr;
        end
        if (start_wb || start_fill || start_ucr || start_ucw) begin
            lk_cached <= bus_req.cached;
            lk_size   <= bus_req.size;
        end
        if (start_ucw) begin
            lk_data <= bus_req.wdata;
            lk_strb <= bus_req.wen;
        end
        if (state == st_ucr_xfer && rvalid) begin
            uc_rdata <= r.data;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= st_idle;
            cnt      <= '0;
            arvalid  <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            ram_busy <= 1'b0;
            uc_valid <= 1'b0;
            uc_wrdy  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    cnt <= '0;
                    // dirty victim goes out first, the retry then fills
                    if (start_wb) begin
                        ram_busy <= 1'b1;
                        state    <= st_wb_prep;
                    end else if (start_fill) begin
                        ram_busy <= 1'b1;
                        state    <= st_fill_prep;
                    end else if (start_ucr) begin
                        state <= st_ucr_prep;
                    end else if (start_ucw) begin
                        state <= st_ucw_prep;
                    end
                end
                st_fill_prep, st_ucr_prep: begin
                    if (!arvalid) begin
                        arvalid <= 1'b1;
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        state   <= lk_cached ? st_fill_xfer : st_ucr_xfer;
                    end
                end
                st_fill_xfer, st_ucr_xfer: begin
                    if (rvalid) begin
                        cnt <= cnt + 1'b1;
                        if (r.last && lk_cached) begin
                            state <= st_fill_end;
                        end else if (r.last) begin
                            uc_valid <= 1'b1;
                            state    <= st_ucr_wait;
                        end
                    end
                end
                st_fill_end: begin
                    ram_busy <= 1'b0;
                    state    <= st_idle;
                end
                st_wb_prep, st_ucw_prep: begin
                    if (!awvalid) begin
                        awvalid <= 1'b1;
                    end else if (awready) begin
                        awvalid <= 1'b0;
                        state   <= lk_cached ? st_wb_xfer : st_ucw_xfer;
                    end
                end
                st_wb_xfer, st_ucw_xfer: begin
                    // one idle cycle per beat lets the ram read settle
                    if (!wvalid) begin
                        wvalid <= 1'b1;
                    end else if (wready) begin
                        wvalid <= 1'b0;
                        cnt    <= cnt + 1'b1;
                        if (w.last) begin
                            state <= lk_cached ? st_wb_end : st_ucw_resp;
                        end
                    end
                end
                st_wb_end: begin
                    if (bvalid) begin
                        ram_busy <= 1'b0;
                        state    <= st_idle;
                    end
                end
                st_ucw_resp: begin
                    if (bvalid) begin
                        uc_wrdy <= 1'b1;
                        state   <= st_ucw_wait;
                    end
                end
                st_ucr_wait, st_ucw_wait: begin
                    // hold the result until the pipeline takes it
                    if (!bus_stall && !stall_out) begin
                        uc_valid <= 1'b0;
                        uc_wrdy  <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dcache_pkg.sv */
/*
 * data cache shared definitions
 * geometry of the direct-mapped cache, AXI length and size codes,
 * and the packed payloads of the processor and memory ports
 */
`default_nettype none

package dcache_pkg;

    // 64 lines of 16 words, 4 KiB
    localparam int line_words    = 16;
    localparam int offset_bits   = 6;
    localparam int index_bits    = 6;
    localparam int tag_bits      = 20;
    localparam int ram_addr_bits = 10;

    // AXI length and size codes
    localparam logic [3:0] burst_len_line   = 4'hf;
    localparam logic [3:0] burst_len_single = 4'h0;
    localparam logic [2:0] size_word        = 3'b010;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wen;
        logic [1:0]  size;
        logic        cached;
    } cpu_req_t;

    // shared by the read and write address channels
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
        logic [2:0]  size;
    } axi_addr_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic                valid;
        logic                dirty;
    } line_state_t;

endpackage

`default_nettype wire

/* design/dcache_tag_array.sv */
/*
 * data cache tag array
 * tag, valid and dirty per line; hit and victim lookup on the
 * current request, plus claim, fill, dirty and writeback updates
 */
`default_nettype none

module dcache_tag_array (
    input  wire                                aclk,
    input  wire                                aresetn,
    input  wire  [31:0]                        lookup_addr,
    output logic                               hit,
    output logic                               victim_dirty,
    output dcache_pkg::line_state_t            victim,
    input  wire                                mark_dirty,
    input  wire                                claim_line,
    input  wire                                fill_done,
    input  wire  [dcache_pkg::index_bits-1:0]  fill_index,
    input  wire                                wb_done
);
    import dcache_pkg::*;

    localparam int lines = 1 << index_bits;

    logic [tag_bits-1:0]   tag_mem [lines];
    logic [lines-1:0]      valid_bits;
    logic [lines-1:0]      dirty_bits;
    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0]   req_tag;
    line_state_t           cur;

    assign req_index = lookup_addr[offset_bits +: index_bits];
    assign req_tag   = lookup_addr[offset_bits + index_bits +: tag_bits];

    assign cur = {tag_mem[req_index], valid_bits[req_index], dirty_bits[req_index]};

    assign hit          = cur.valid && (cur.tag == req_tag);
    assign victim       = cur;
    // valid line of another tag holding modified data
    assign victim_dirty = cur.valid && cur.dirty && !hit;

    always_ff @(posedge aclk) begin
        if (claim_line) begin
            tag_mem[req_index] <= req_tag;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            // line stays invalid until its fill ends
            if (claim_line) begin
                valid_bits[req_index] <= 1'b0;
                dirty_bits[req_index] <= 1'b0;
            end
            if (fill_done) begin
                valid_bits[fill_index] <= 1'b1;
            end
            if (mark_dirty) begin
                dirty_bits[req_index] <= 1'b1;
            end
            if (wb_done) begin
                dirty_bits[fill_index] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
/*
 * write-back direct-mapped data cache
 * processor request port in front, AXI master port behind;
 * hits finish in one cycle, misses and uncached accesses stall
 */
`default_nettype none

module dcache_top (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire                          bus_en,
    input  wire  dcache_pkg::cpu_req_t   bus_req,
    input  wire                          bus_stall,
    output logic [31:0]                  bus_rdata,
    output logic                         bus_streq,
    output dcache_pkg::axi_addr_t        ar,
    output logic                         arvalid,
    input  wire                          arready,
    input  wire  dcache_pkg::axi_r_t     r,
    input  wire                          rvalid,
    output dcache_pkg::axi_addr_t        aw,
    output logic                         awvalid,
    input  wire                          awready,
    output dcache_pkg::axi_w_t           w,
    output logic                         wvalid,
    input  wire                          wready,
    input  wire                          bvalid
);
    import dcache_pkg::*;

    logic                     hit;
    logic                     victim_dirty;
    line_state_t              victim;
    logic                     mark_dirty;
    logic                     claim_line;
    logic                     fill_done;
    logic                     wb_done;
    logic [index_bits-1:0]    fill_index;
    logic                     ram_busy;
    logic [ram_addr_bits-1:0] ram_b_addr;
    logic [3:0]               ram_b_wen;
    logic [31:0]              ram_b_wdata;
    logic [31:0]              ram_b_rdata;
    logic [3:0]               ram_a_wen;
    logic [31:0]              ram_a_rdata;
    logic [31:0]              uc_rdata;
    logic                     uc_ready;
    logic                     accept;
    logic                     cached_q;

    assign bus_streq = ram_busy || (bus_en && (bus_req.cached ? !hit : !uc_ready));
    assign accept    = bus_en && !bus_streq;

    // accepted cached access is always a hit
    assign ram_a_wen  = (accept && bus_req.cached) ? bus_req.wen : 4'h0;
    assign mark_dirty = accept && bus_req.cached && (|bus_req.wen);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cached_q <= 1'b0;
        end else begin
            cached_q <= bus_req.cached;
        end
    end

    assign bus_rdata = cached_q ? ram_a_rdata : uc_rdata;

    dcache_data_ram data_ram_i (
        .aclk         (aclk),
        .port_a_addr  (bus_req.addr[2 +: ram_addr_bits]),
        .port_a_wen   (ram_a_wen),
        .port_a_wdata (bus_req.wdata),
        .port_a_rdata (ram_a_rdata),
        .port_b_addr  (ram_b_addr),
        .port_b_wen   (ram_b_wen),
        .port_b_wdata (ram_b_wdata),
        .port_b_rdata (ram_b_rdata)
    );

    dcache_tag_array tag_array_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .lookup_addr  (bus_req.addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim       (victim),
        .mark_dirty   (mark_dirty),
        .claim_line   (claim_line),
        .fill_done    (fill_done),
        .fill_index   (fill_index),
        .wb_done      (wb_done)
    );

    dcache_miss_fsm miss_fsm_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .bus_en       (bus_en),
        .bus_req      (bus_req),
        .bus_stall    (bus_stall),
        .stall_out    (bus_streq),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim       (victim),
        .claim_line   (claim_line),
        .fill_done    (fill_done),
        .wb_done      (wb_done),
        .fill_index   (fill_index),
        .ram_busy     (ram_busy),
        .ram_b_addr   (ram_b_addr),
        .ram_b_wen    (ram_b_wen),
        .ram_b_wdata  (ram_b_wdata),
        .ram_b_rdata  (ram_b_rdata),
        .uc_rdata     (uc_rdata),
        .uc_ready     (uc_ready),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_tb -f verilog.f -o dcache_sim
./obj_dir/dcache_sim > sim.log
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    exit 1
fi

/* verilog.f */
design/dcache_pkg.sv
design/dcache_data_ram.sv
design/dcache_tag_array.sv
design/dcache_miss_fsm.sv
design/dcache_top.sv
bench/tb_clock_gen.sv
bench/axi_mem_model.sv
bench/dcache_tb.sv
